//--- test/ranger_cases.txt
# name trig_cycles timeout threshold near_hits echo_delay echo_width
# A width of 0 means no echo, so the measurement times out
echo_short    8  200 40 1 5  12
echo_long     16 300 40 1 3  120
trig_one      1  200 40 1 2  7
echo_one      5  200 40 1 2  1
timeout_a     6  60  40 1 0  0
near_below    10 200 40 1 4  39
near_at       10 200 40 1 4  40
near_above    10 200 40 1 4  41
alert_hit1    10 200 40 3 2  15
alert_hit2    10 200 40 3 6  20
alert_hit3    10 200 40 3 1  25
alert_far     10 200 40 3 2  80
alert_again1  12 200 40 3 3  10
alert_again2  12 200 40 3 3  11
alert_again3  12 200 40 3 3  12
alert_timeout 12 60  40 3 0  0

//--- flist.f
verilog/ranger_pkg.sv
verilog/echo_ranger.sv
verilog/proximity_alert.sv
verilog/ranger_apb_regs.sv
verilog/ranger_top.sv
test/ranger_checker.sv
test/tb_ranger.sv

//--- Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_ranger
RTL_TOP   ?= ranger_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only verilog/ranger_pkg.sv verilog/echo_ranger.sv \
		verilog/proximity_alert.sv verilog/ranger_apb_regs.sv verilog/ranger_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_ranger.sv
`timescale 1ns/100ps

module tb_ranger
    import ranger_pkg::*;
;

    logic                  clk;
    logic                  reset_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  echo;
    logic                  trigger;
    logic                  alert;
    logic                  polling;
    logic                  test_done;
    logic [127:0]          test_name;
    logic                  aborted;     // A wait timed out or no cases file
    int                    error_count;
    int                    test_count;
    int                    failed_tests;

    ranger_top #(.COUNT_W(count_w)) i_dut (
        .clk(clk), .reset_n(reset_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .echo(echo), .trigger(trigger), .alert(alert)
    );

    ranger_checker i_checker (
        .clk(clk), .reset_n(reset_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .echo(echo), .trigger(trigger), .alert(alert),
        .polling(polling), .test_done(test_done), .test_name(test_name),
        .error_count(error_count), .test_count(test_count), .failed_tests(failed_tests)
    );

    always #5 clk = !clk;

    task automatic flag_timeout(input string what);
        $display("Timeout while waiting for %0s", what);
        aborted = 1'b1;
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        psel    <= 1'b1;    // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < 16);
        if (!pready) flag_timeout("pready");
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_trigger(input logic level, input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (trigger !== level && n < limit);
        if (trigger !== level) flag_timeout(level ? "trigger to rise" : "trigger to fall");
    endtask

    task automatic poll_done();
        logic [31:0] st;
        int          n;
        n = 0;
        @(posedge clk);
        polling <= 1'b1;
        do begin
            apb_read(addr_status, st);
            n++;
        end while (!st[0] && n < 400);
        if (!st[0]) flag_timeout("done status bit");
        @(posedge clk);
        polling <= 1'b0;
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin : stimulus
        int          fd;
        int          n;
        int          trig_c;
        int          tmo;
        int          thr;
        int          hits;
        int          dly;
        int          width;
        string       line;
        logic [127:0] name;
        logic [31:0] rd;
        clk       = 1'b0;
        reset_n   = 1'b1;      // Active high
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        echo      = 1'b0;
        polling   = 1'b0;
        test_done = 1'b0;
        aborted   = 1'b0;
        test_name = "reset_idle";
        void'($urandom(32'hef3f_c1b4));
        repeat (16) @(posedge clk);
        reset_n <= 1'b0;

        // Defaults and an idle trigger
        repeat (50) @(posedge clk);
        for (int a = 0; a < 8; a++) apb_read(8'(a * 4), rd);
        apb_write(addr_pause, 32'd20);
        finish_test();

        fd = $fopen("test/ranger_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/ranger_cases.txt");
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %d %d %d %d %d %d",
                            name, trig_c, tmo, thr, hits, dly, width);
                if (n != 7) continue;
                @(posedge clk);
                test_name <= name;
                apb_write(addr_trig, 32'(trig_c));
                apb_write(addr_timeout, 32'(tmo));
                apb_write(addr_thresh, 32'(thr));
                apb_write(addr_ctrl, {16'b0, 8'(hits), 8'h01});
                wait_trigger(1'b1, 5000);
                if (aborted) break;
                wait_trigger(1'b0, 70000);
                if (aborted) break;
                apb_write(addr_ctrl, {16'b0, 8'(hits), 8'h00});   // Single shot
                repeat (dly + int'($urandom % 21)) @(posedge clk);
                if (width > 0) begin
                    @(posedge clk);
                    echo <= 1'b1;
                    repeat (width) @(posedge clk);
                    echo <= 1'b0;
                end
                poll_done();
                if (aborted) break;
                apb_read(addr_result, rd);
                apb_read(addr_status, rd);
                apb_read(addr_meas_count, rd);
                apb_write(addr_status, 32'h3);
                apb_read(addr_status, rd);
                finish_test();
            end
            $fclose(fd);
        end

        if (!aborted) begin
            @(posedge clk);
            test_name <= "apb_unmapped";
            apb_write(8'h20, 32'hFFFF_FFFF);
            apb_read(8'h24, rd);
            apb_write(8'h03, 32'h0000_0001);
            for (int a = 0; a < 8; a++) apb_read(8'(a * 4), rd);
            finish_test();
        end

        repeat (4) @(posedge clk);
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- test/ranger_checker.sv
`timescale 1ns/100ps

module ranger_checker
    import ranger_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    input  logic [apb_data_w-1:0] prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    input  logic                  echo,
    input  logic                  trigger,
    input  logic                  alert,
    input  logic                  polling,     // Status reads not checked while high
    input  logic                  test_done,
    input  logic [127:0]          test_name,
    output int                    error_count,
    output int                    test_count,
    output int                    failed_tests
);

    logic        en_m;
    logic [7:0]  hits_m;
    logic [15:0] trig_m;
    logic [21:0] timeout_m;
    logic [21:0] thresh_m;
    logic [15:0] pause_m;
    logic [21:0] count_m;
    logic [15:0] meas_m;
    logic        done_m;
    logic        to_m;
    logic        near_m;
    logic        polling_q;
    int          run_m;         // Consecutive near measurements
    int          trig_run;
    int          echo_run;
    int          echo_width;
    int          test_errors;

    function automatic logic is_mapped(input logic [7:0] addr);
        return addr inside {8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14, 8'h18, 8'h1C};
    endfunction

    function automatic logic alert_exp();
        int need;
        need = (hits_m == 8'd0) ? 1 : int'(hits_m);
        return run_m >= need;
    endfunction

    task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %0s: %0s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
        error_count++;
        test_errors++;
    endtask

    initial begin
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
    end

    always @(negedge clk) begin : watch
        logic [31:0] exp;
        logic        to_now;
        int          trig_exp;
        if (reset_n) begin
            en_m = 1'b0;            // Values from the reset table
            hits_m = 8'd1;
            trig_m = 16'd500;
            timeout_m = 22'd900000;
            thresh_m = 22'd30000;
            pause_m = 16'd1000;
            count_m = '0;
            meas_m = '0;
            done_m = 1'b0;
            to_m = 1'b0;
            near_m = 1'b0;
            polling_q = 1'b0;
            run_m = 0;
            trig_run = 0;
            echo_run = 0;
            echo_width = 0;
            test_errors = 0;
        end else begin
            // APB access phase
            if (psel && penable) begin
                if (pready !== 1'b1) begin
                    report("pready", 32'd1, {31'b0, pready});
                end
                if (pslverr !== !is_mapped(paddr)) begin
                    report("pslverr", {31'b0, !is_mapped(paddr)}, {31'b0, pslverr});
                end
                if (pwrite && is_mapped(paddr)) begin
                    case (paddr)
                        8'h00: begin
                            en_m   = pwdata[0];
                            hits_m = pwdata[15:8];
                        end
                        8'h04: trig_m    = pwdata[15:0];
                        8'h08: timeout_m = pwdata[21:0];
                        8'h0C: thresh_m  = pwdata[21:0];
                        8'h10: pause_m   = pwdata[15:0];
                        8'h18: begin
                            if (pwdata[0]) done_m = 1'b0;   // Write one to clear
                            if (pwdata[1]) to_m = 1'b0;
                        end
                        default: ;
                    endcase
                end else if (!pwrite && is_mapped(paddr)) begin
                    case (paddr)
                        8'h00:   exp = {16'b0, hits_m, 7'b0, en_m};
                        8'h04:   exp = {16'b0, trig_m};
                        8'h08:   exp = {10'b0, timeout_m};
                        8'h0C:   exp = {10'b0, thresh_m};
                        8'h10:   exp = {16'b0, pause_m};
                        8'h14:   exp = {10'b0, count_m};
                        8'h18:   exp = {28'b0, alert_exp(), near_m, to_m, done_m};
                        default: exp = {16'b0, meas_m};
                    endcase
                    if (!(paddr == 8'h18 && polling) && prdata !== exp) begin
                        report($sformatf("read of 0x%02h", paddr), exp, prdata);
                    end
                end
            end

            if (trigger) begin
                if (!en_m && trig_run == 0) begin
                    $display("ERROR %0s: trigger rose while enable was clear", test_name);
                    error_count++;
                    test_errors++;
                end
                trig_run++;
            end else if (trig_run > 0) begin
                trig_exp = (trig_m == 16'd0) ? 1 : int'(trig_m);
                if (trig_run != trig_exp) begin
                    report("trigger width", trig_exp, trig_run);
                end
                trig_run   = 0;
                echo_run   = 0;     // New measurement starts
                echo_width = 0;
            end

            if (echo) begin
                echo_run++;
            end else if (echo_run > 0) begin
                echo_width = echo_run;
                echo_run   = 0;
            end

            // Measurement complete once the done poll has finished
            if (polling_q && !polling) begin
                to_now  = (echo_width == 0);
                count_m = 22'(echo_width);
                near_m  = !to_now && (22'(echo_width) < thresh_m);
                if (!near_m) run_m = 0;
                else if (run_m < 255) run_m++;
                meas_m = meas_m + 16'd1;
                done_m = 1'b1;
                if (to_now) to_m = 1'b1;
            end
            polling_q = polling;

            if (test_done) begin
                if (alert !== alert_exp()) begin
                    report("alert", {31'b0, alert_exp()}, {31'b0, alert});
                end
                test_count++;
                if (test_errors == 0) begin
                    $display("PASS %0s", test_name);
                end else begin
                    $display("FAIL %0s with %0d error(s)", test_name, test_errors);
                    failed_tests++;
                end
                test_errors = 0;
            end
        end
    end

endmodule

//--- verilog/ranger_top.sv
`timescale 1ns/100ps

module ranger_top
    import ranger_pkg::*;
#(
    parameter int COUNT_W = count_w
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  echo,
    output logic                  trigger,
    output logic                  alert
);

    ranger_cfg_t    cfg;
    logic [7:0]     near_hits;
    ranger_result_t raw_result;     // From the timer, near not yet set
    ranger_result_t result;         // Classified

    ranger_apb_regs #(.COUNT_W(COUNT_W)) i_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .result    (result),
        .alert     (alert),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cfg       (cfg),
        .near_hits (near_hits)
    );

    echo_ranger #(.COUNT_W(COUNT_W)) i_ranger (
        .clk     (clk),
        .reset_n (reset_n),
        .echo    (echo),
        .cfg     (cfg),
        .trigger (trigger),
        .result  (raw_result)
    );

    proximity_alert #(.COUNT_W(COUNT_W)) i_alert (
        .clk            (clk),
        .reset_n        (reset_n),
        .raw_result     (raw_result),
        .near_threshold (cfg.near_threshold),
        .near_hits      (near_hits),
        .result         (result),
        .alert          (alert)
    );

endmodule

//--- verilog/ranger_apb_regs.sv
`timescale 1ns/100ps

module ranger_apb_regs
    import ranger_pkg::*;
#(
    parameter int COUNT_W = count_w
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    input  ranger_result_t        result,
    input  logic                  alert,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output ranger_cfg_t           cfg,
    output logic [7:0]            near_hits
);

    logic                  setup;
    logic                  wr_en;
    logic                  mapped;
    logic [apb_data_w-1:0] rdata;
    logic [COUNT_W-1:0]    last_count;
    logic [15:0]           meas_count;
    logic                  done_flag;
    logic                  timeout_flag;
    logic                  near_flag;

    assign pready = 1'b1;   // No wait states
    assign setup  = psel && !penable;
    assign wr_en  = psel && penable && pwrite && mapped;

    // Address decode and read mux
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (paddr)
            addr_ctrl:       rdata = apb_data_w'({near_hits, 7'b0, cfg.enable});
            addr_trig:       rdata = apb_data_w'(cfg.trig_cycles);
            addr_timeout:    rdata = apb_data_w'(cfg.timeout_cycles);
            addr_thresh:     rdata = apb_data_w'(cfg.near_threshold);
            addr_pause:      rdata = apb_data_w'(cfg.pause_cycles);
            addr_result:     rdata = apb_data_w'(last_count);
            addr_status:     rdata = apb_data_w'({alert, near_flag, timeout_flag, done_flag});
            addr_meas_count: rdata = apb_data_w'(meas_count);
            default:         mapped = 1'b0;
        endcase
    end

    // Configuration registers
    always_ff @(posedge clk) begin
        if (reset_n) begin
            cfg.enable         <= 1'b0;
            cfg.trig_cycles    <= rst_trig_cycles;
            cfg.timeout_cycles <= rst_timeout_cycles;
            cfg.near_threshold <= rst_near_threshold;
            cfg.pause_cycles   <= rst_pause_cycles;
            near_hits          <= rst_near_hits;
        end else if (wr_en) begin
            case (paddr)
                addr_ctrl: begin
                    cfg.enable <= pwdata[0];
                    near_hits  <= pwdata[15:8];
                end
                addr_trig:    cfg.trig_cycles    <= pwdata[15:0];
                addr_timeout: cfg.timeout_cycles <= pwdata[count_w-1:0];
                addr_thresh:  cfg.near_threshold <= pwdata[count_w-1:0];
                addr_pause:   cfg.pause_cycles   <= pwdata[15:0];
                default: ;    // Read-only or status, handled below
            endcase
        end
    end

    // Result capture and sticky status
    always_ff @(posedge clk) begin
        if (reset_n) begin
            last_count   <= '0;
            meas_count   <= '0;
            done_flag    <= 1'b0;
            timeout_flag <= 1'b0;
            near_flag    <= 1'b0;
        end else begin
            if (wr_en && (paddr == addr_status)) begin
                if (pwdata[0]) done_flag    <= 1'b0;
                if (pwdata[1]) timeout_flag <= 1'b0;
            end
            // A new result wins over a simultaneous clear
            if (result.valid) begin
                last_count <= COUNT_W'(result.echo_count);
                meas_count <= meas_count + 16'd1;
                done_flag  <= 1'b1;
                near_flag  <= result.near;
                if (result.timed_out) begin
                    timeout_flag <= 1'b1;
                end
            end
        end
    end

    // Read data and error are loaded in setup so they hold through the access phase
    always_ff @(posedge clk) begin
        if (reset_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && !mapped;
            prdata  <= (setup && !pwrite) ? rdata : '0;
        end
    end

endmodule

//--- verilog/proximity_alert.sv
`timescale 1ns/100ps

module proximity_alert
    import ranger_pkg::*;
#(
    parameter int COUNT_W = count_w
) (
    input  logic               clk,
    input  logic               reset_n,
    input  ranger_result_t     raw_result,
    input  logic [COUNT_W-1:0] near_threshold,
    input  logic [7:0]         near_hits,
    output ranger_result_t     result,
    output logic               alert
);

    logic               near_now;
    logic [7:0]         hits_needed;
    logic [7:0]         hit_cnt;    // Consecutive near results
    logic               valid_q;
    logic [count_w-1:0] count_q;
    logic               timed_out_q;
    logic               near_q;

    assign near_now = !raw_result.timed_out &&
                      (COUNT_W'(raw_result.echo_count) < near_threshold);

    assign hits_needed = (near_hits == 8'd0) ? 8'd1 : near_hits; // Zero acts as one

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= 1'b0;
            hit_cnt <= '0;
        end else begin
            valid_q <= raw_result.valid;
            if (raw_result.valid) begin
                if (!near_now) begin
                    hit_cnt <= '0;              // Far or timeout breaks the run
                end else if (hit_cnt != 8'hFF) begin
                    hit_cnt <= hit_cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (raw_result.valid) begin
            count_q     <= raw_result.echo_count;
            timed_out_q <= raw_result.timed_out;
            near_q      <= near_now;
        end
    end

    assign result = '{
        echo_count: count_q,
        valid:      valid_q,
        timed_out:  timed_out_q,
        near:       near_q
    };

    assign alert = (hit_cnt >= hits_needed);

endmodule

//--- verilog/echo_ranger.sv
`timescale 1ns/100ps

module echo_ranger
    import ranger_pkg::*;
#(
    parameter int COUNT_W = count_w
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           echo,
    input  ranger_cfg_t    cfg,
    output logic           trigger,
    output ranger_result_t result
);

    ranger_state_e state;

    logic [COUNT_W-1:0] cnt;        // Shared by pause, trigger and timeout
    logic [COUNT_W-1:0] cnt_nxt;
    logic [COUNT_W-1:0] width_cnt;  // Echo high time in cycles
    logic               echo_meta;
    logic               echo_sync;
    logic               timed_out;
    logic               pause_hit;
    logic               trig_hit;
    logic               timeout_hit;

    assign cnt_nxt = cnt + COUNT_W'(1);

    // Terminal counts, a zero setting behaves like one
    assign pause_hit   = cnt_nxt >= COUNT_W'(cfg.pause_cycles);
    assign trig_hit    = cnt_nxt >= COUNT_W'(cfg.trig_cycles);
    assign timeout_hit = cnt_nxt >= COUNT_W'(cfg.timeout_cycles);

    // Two stage synchronizer for the asynchronous echo pin
    always_ff @(posedge clk) begin
        if (reset_n) begin
            echo_meta <= 1'b0;
            echo_sync <= 1'b0;
        end else begin
            echo_meta <= echo;
            echo_sync <= echo_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state     <= idle;
            cnt       <= '0;
            width_cnt <= '0;
            timed_out <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    width_cnt <= '0;
                    if (!cfg.enable) begin
                        cnt <= '0;              // Hold off while disabled
                    end else if (pause_hit) begin
                        cnt   <= '0;
                        state <= trig;
                    end else begin
                        cnt <= cnt_nxt;
                    end
                end

                trig: begin
                    if (trig_hit) begin
                        cnt   <= '0;
                        state <= wait_echo;
                    end else begin
                        cnt <= cnt_nxt;
                    end
                end

                wait_echo: begin
                    if (echo_sync) begin
                        width_cnt <= COUNT_W'(1);  // First high cycle
                        state     <= measure;
                    end else if (timeout_hit) begin
                        width_cnt <= '0;
                        timed_out <= 1'b1;
                        state     <= done;
                    end else begin
                        cnt <= cnt_nxt;
                    end
                end

                measure: begin
                    if (echo_sync) begin
                        if (width_cnt != '1) begin
                            width_cnt <= width_cnt + COUNT_W'(1); // Saturates
                        end
                    end else begin
                        timed_out <= 1'b0;
                        state     <= done;
                    end
                end

                done: begin
                    cnt   <= '0;
                    state <= idle;
                end

                default: begin
                    cnt   <= '0;
                    state <= idle;
                end
            endcase
        end
    end

    assign trigger = (state == trig);

    // Near is filled in downstream by the classifier
    assign result = '{
        echo_count: count_w'(width_cnt),
        valid:      (state == done),
        timed_out:  timed_out,
        near:       1'b0
    };

endmodule

//--- verilog/ranger_pkg.sv
package ranger_pkg;

    // Counter width for echo time, timeout and threshold
    localparam int count_w = 22;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // Register map, byte addresses
    localparam logic [apb_addr_w-1:0] addr_ctrl       = 8'h00; // enable, near_hits
    localparam logic [apb_addr_w-1:0] addr_trig       = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_timeout    = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_thresh     = 8'h0C;
    localparam logic [apb_addr_w-1:0] addr_pause      = 8'h10;
    localparam logic [apb_addr_w-1:0] addr_result     = 8'h14; // Read only
    localparam logic [apb_addr_w-1:0] addr_status     = 8'h18; // W1C sticky bits
    localparam logic [apb_addr_w-1:0] addr_meas_count = 8'h1C;

    // Configuration values after reset
    localparam logic [15:0]        rst_trig_cycles    = 16'd500;
    localparam logic [count_w-1:0] rst_timeout_cycles = count_w'(900000);
    localparam logic [count_w-1:0] rst_near_threshold = count_w'(30000);
    localparam logic [15:0]        rst_pause_cycles   = 16'd1000;
    localparam logic [7:0]         rst_near_hits      = 8'd1;

    typedef enum logic [2:0] {
        idle,       // Pause between measurements
        trig,       // Trigger high
        wait_echo,  // Waiting for echo rise
        measure,    // Echo high, counting
        done        // Publish result
    } ranger_state_e;

    typedef struct packed {
        logic               enable;
        logic [15:0]        trig_cycles;
        logic [count_w-1:0] timeout_cycles;
        logic [count_w-1:0] near_threshold;
        logic [15:0]        pause_cycles;
    } ranger_cfg_t;

    typedef struct packed {
        logic [count_w-1:0] echo_count;
        logic               valid;      // Single cycle strobe
        logic               timed_out;
        logic               near;
    } ranger_result_t;

endpackage
